//--- vlog.f
common/mfu_cfg_pkg.sv
common/mfu_op_pkg.sv
rtl/vrf/vrf_bank_ram.sv
rtl/vrf/vrf.sv
rtl/mfu_lane.sv
rtl/mfu_datapath.sv
rtl/mfu_top.sv
dv/tb_mfu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MFU testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tb_mfu \
    --Mdir obj_dir \
    -o tb_mfu_sim \
    -f vlog.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_mfu_sim)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF 'All tests passed!'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- dv/tb_mfu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mfu;

    import mfu_cfg_pkg::*;
    import mfu_op_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int RESET_CYC  = 8;
    // Roughly 300 cycles of stimulus plus margin
    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      resetn;
    logic      in_valid;
    mfu_op_t   op;
    vec_t      primary;
    vrf_addr_t vrf_rd_addr;
    logic      vrf_wr_en;
    vec_t      vrf_wr_data;
    wire       out_valid;
    vec_t      out_data;

    // Shadow VRF and the expected results in issue order
    vec_t      shadow [1 << VRF_AW];
    vrf_addr_t wr_count;
    vec_t      exp_q [$];
    string     name_q [$];
    logic [1:0] valid_hist;

    int value_errs;
    int proto_errs;
    int cycles;

    mfu_top i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .op          (op),
        .primary     (primary),
        .vrf_rd_addr (vrf_rd_addr),
        .vrf_wr_en   (vrf_wr_en),
        .vrf_wr_data (vrf_wr_data),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected value of one lane
    function automatic elem_t expect_lane(input mfu_op_t o, input elem_t a, input elem_t b);
        int unsigned p;
        case (o)
            OP_RELU:   expect_lane = ($signed(a) < 0) ? 16'h0000 : a;
            OP_ADD:    expect_lane = elem_t'(32'(a) + 32'(b));
            OP_MUL: begin
                p = (32'(a) & 32'hff) * (32'(b) & 32'hff);
                expect_lane = elem_t'(p);
            end
            default:   expect_lane = a;
        endcase
    endfunction

    function automatic vec_t random_vec();
        vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = elem_t'($urandom);
        end
        return v;
    endfunction

    task automatic write_vrf(input vec_t data);
        vrf_wr_en   = 1'b1;
        vrf_wr_data = data;
        shadow[wr_count] = data;
        wr_count = wr_count + vrf_addr_t'(1);
        @(posedge clk);
        #DRIVE_DLY;
        vrf_wr_en = 1'b0;
    endtask

    task automatic issue(input mfu_op_t o, input vec_t p, input vrf_addr_t addr,
                         input string test);
        vec_t stored;
        vec_t exp;
        stored = shadow[addr];
        for (int i = 0; i < LANES; i++) begin
            exp[i] = expect_lane(o, p[i], stored[i]);
        end
        exp_q.push_back(exp);
        name_q.push_back(test);
        in_valid    = 1'b1;
        op          = o;
        primary     = p;
        vrf_rd_addr = addr;
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
    endtask

    // In_valid as seen by the DUT over the last two edges
    always @(posedge clk) begin
        if (resetn) begin
            valid_hist <= 2'b00;
        end else begin
            valid_hist <= {valid_hist[0], in_valid};
        end
    end

    always @(negedge clk) begin
        vec_t  exp;
        string test;
        assert (out_valid === valid_hist[1]) else begin
            proto_errs++;
            $display("out_valid is %b at %0t but the input two cycles earlier says %b",
                     out_valid, $time, valid_hist[1]);
        end
        if (out_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("Output at %0t with no input waiting for a result", $time);
            end
            if (exp_q.size() != 0) begin
                exp  = exp_q.pop_front();
                test = name_q.pop_front();
                assert (out_data === exp) else begin
                    value_errs++;
                    $display("[FAIL] %s: expected %h, actual %h", test, exp, out_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        vec_t v;
        void'($urandom(90));
        resetn      = 1'b1;
        in_valid    = 1'b0;
        op          = OP_BYPASS;
        primary     = '0;
        vrf_rd_addr = '0;
        vrf_wr_en   = 1'b0;
        vrf_wr_data = '0;
        wr_count    = '0;
        valid_hist  = 2'b00;
        value_errs  = 0;
        proto_errs  = 0;
        cycles      = 0;

        repeat (RESET_CYC) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
        resetn = 1'b0;
        idle_cycles(4);

        // Fill addresses 0 to 15 in write order
        for (int i = 0; i < 16; i++) begin
            write_vrf(random_vec());
        end
        idle_cycles(2);

        for (int i = 0; i < 40; i++) begin
            issue(OP_ADD, random_vec(), vrf_addr_t'($urandom_range(0, 15)), "vrf_add");
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles(1);
            end
        end
        idle_cycles(3);

        for (int i = 0; i < 40; i++) begin
            issue(OP_MUL, random_vec(), vrf_addr_t'($urandom_range(0, 15)), "vrf_mul");
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles(1);
            end
        end
        idle_cycles(3);

        // Mixed signs with lane 0 always negative and lane 1 always positive
        for (int i = 0; i < 40; i++) begin
            v = random_vec();
            for (int l = 0; l < LANES; l++) begin
                v[l][ELEM_W-1] = 1'($urandom_range(0, 1));
            end
            v[0][ELEM_W-1] = 1'b1;
            v[1][ELEM_W-1] = 1'b0;
            issue(OP_RELU, v, vrf_addr_t'($urandom_range(0, 15)), "relu");
        end
        idle_cycles(3);

        // Back-to-back burst with every fourth input a bypass
        for (int i = 0; i < 100; i++) begin
            if (i % 4 == 0) begin
                issue(OP_BYPASS, random_vec(), vrf_addr_t'($urandom_range(0, 15)),
                      "burst_bypass");
            end else begin
                issue(mfu_op_t'($urandom_range(0, 3)), random_vec(),
                      vrf_addr_t'($urandom_range(0, 15)), "burst_mixed");
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle_cycles(4);

        $display("Errors: value=%0d protocol=%0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/mfu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mfu_top (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         in_valid,
    input  wire mfu_op_pkg::mfu_op_t    op,
    input  wire mfu_cfg_pkg::vec_t      primary,
    input  wire mfu_cfg_pkg::vrf_addr_t vrf_rd_addr,
    input  wire                         vrf_wr_en,
    input  wire mfu_cfg_pkg::vec_t      vrf_wr_data,
    output wire                         out_valid,
    output wire mfu_cfg_pkg::vec_t      out_data
);

    import mfu_cfg_pkg::*;

    // Operand read back from the VRF, one cycle after the address
    wire vec_t vrf_rd_data;

    // Shared VRF for add and multiply
    vrf u_vrf (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en   (vrf_wr_en),
        .wr_data (vrf_wr_data),
        .rd_addr (vrf_rd_addr),
        .rd_data (vrf_rd_data)
    );

    // Two-cycle pipeline from in_valid to out_valid
    mfu_datapath u_datapath (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .op        (op),
        .primary   (primary),
        .vrf_data  (vrf_rd_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- rtl/mfu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mfu_datapath (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      in_valid,
    input  wire mfu_op_pkg::mfu_op_t op,
    input  wire mfu_cfg_pkg::vec_t   primary,
    input  wire mfu_cfg_pkg::vec_t   vrf_data,
    output logic                     out_valid,
    output mfu_cfg_pkg::vec_t        out_data
);

    import mfu_cfg_pkg::*;
    import mfu_op_pkg::*;

    // Stage 1 lines up with the VRF read data
    logic    s1_valid;
    mfu_op_t s1_op;
    vec_t    s1_primary;

    // Lane results computed combinationally from stage 1
    wire vec_t lane_y;

    // Valid pipeline
    always_ff @(posedge clk) begin
        if (resetn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op      <= op;
            s1_primary <= primary;
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        mfu_lane u_lane (
            .op (s1_op),
            .a  (s1_primary[i]),
            .b  (vrf_data[i]),
            .y  (lane_y[i])
        );
    end

    // Stage 2 holds the result until the next valid vector
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_data <= lane_y;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mfu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mfu_lane (
    input  wire mfu_op_pkg::mfu_op_t op,
    input  wire mfu_cfg_pkg::elem_t  a,
    input  wire mfu_cfg_pkg::elem_t  b,
    output mfu_cfg_pkg::elem_t       y
);

    import mfu_cfg_pkg::*;
    import mfu_op_pkg::*;

    logic [2*MUL_IN_W-1:0] prod;
    elem_t                 relu;
    elem_t                 sum;

    // Unsigned product of the low bytes
    assign prod = a[MUL_IN_W-1:0] * b[MUL_IN_W-1:0];

    // Negative elements clamp to zero
    assign relu = a[ELEM_W-1] ? '0 : a;

    // Wraps at the element width
    assign sum = a + b;

    always_comb begin
        case (op)
            OP_RELU: begin
                y = relu;
            end
            OP_ADD: begin
                y = sum;
            end
            OP_MUL: begin
                y = elem_t'(prod);
            end
            OP_BYPASS: begin
                y = a;
            end
            default: begin
                y = a;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/vrf/vrf.sv
`timescale 1ns/1ps
`default_nettype none

module vrf (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    wr_en,
    input  wire mfu_cfg_pkg::vec_t      wr_data,
    input  wire mfu_cfg_pkg::vrf_addr_t rd_addr,
    output wire mfu_cfg_pkg::vec_t      rd_data
);

    import mfu_cfg_pkg::*;

    // Write pointer that advances once per written vector
    vrf_addr_t wr_ptr;

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            // Wraps at the top of the array
            wr_ptr <= wr_ptr + vrf_addr_t'(1);
        end
    end

    // One bank per lane
    // All banks share the pointer and the read address
    for (genvar i = 0; i < LANES; i++) begin : g_bank
        vrf_bank_ram #(
            .AWIDTH (VRF_AW),
            .DWIDTH (ELEM_W)
        ) u_bank (
            .clk     (clk),
            .wr_en   (wr_en),
            .wr_addr (wr_ptr),
            .wr_data (wr_data[i]),
            .rd_addr (rd_addr),
            .rd_data (rd_data[i])
        );
    end

endmodule

`default_nettype wire

//--- rtl/vrf/vrf_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_bank_ram #(
    parameter int AWIDTH = 10,
    parameter int DWIDTH = 16
) (
    input  wire               clk,
    input  wire               wr_en,
    input  wire  [AWIDTH-1:0] wr_addr,
    input  wire  [DWIDTH-1:0] wr_data,
    input  wire  [AWIDTH-1:0] rd_addr,
    output logic [DWIDTH-1:0] rd_data
);

    localparam int DEPTH = 1 << AWIDTH;

    logic [DWIDTH-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read
    // A read of the word being written returns its old contents
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- common/mfu_op_pkg.sv
`default_nettype none

package mfu_op_pkg;

    // Width of the operation field
    localparam int OP_W = 2;

    // Operation select carried with each input vector
    typedef enum logic [OP_W-1:0] {
        OP_RELU   = 2'b00,
        OP_ADD    = 2'b01,
        OP_MUL    = 2'b10,
        OP_BYPASS = 2'b11
    } mfu_op_t;

endpackage

`default_nettype wire

//--- common/mfu_cfg_pkg.sv
`default_nettype none

package mfu_cfg_pkg;

    // Vector shape
    localparam int LANES  = 10;
    localparam int ELEM_W = 16;

    // Each multiplier operand is taken from an element's low bits
    localparam int MUL_IN_W = 8;

    // VRF sizing for 1024 vectors
    localparam int VRF_AW = 10;

    // One element of a vector
    typedef logic [ELEM_W-1:0] elem_t;

    // Lane 0 sits in the low bits
    typedef elem_t [LANES-1:0] vec_t;

    // VRF address
    typedef logic [VRF_AW-1:0] vrf_addr_t;

endpackage

`default_nettype wire
